// ==== include/ddrc_init_macros.svh ====
// DDR3 init constants
`ifndef DDRC_INIT_MACROS_SVH
`define DDRC_INIT_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// widths, depth and status codes
//////////////////////////////////////////////////////////////////////
`define DDRC_REG_ADDR_W   12
`define DDRC_REG_DATA_W   32
`define DDRC_INIT_ENTRIES 24
`define CFG_FIFO_DEPTH    4
`define DDRC_STAT_ADDR    12'h004
`define DDRC_DONE_CODE    2'b01 // normal operating mode in stat[1:0].

//////////////////////////////////////////////////////////////////////
// refresh, mode register and timing values
//////////////////////////////////////////////////////////////////////
`define DDRC_TREFI    12'h062
`define DDRC_TRFC_MIN 10'h08c
`define DDRC_MR       16'h1108
`define DDRC_EMR      16'h0001
`define DDRC_EMR2     16'h0000
`define DDRC_EMR3     16'h0000
// wr2pre, t_faw, t_ras_max, t_ras_min.
`define DDRC_DRAMTMG0 {1'b0, 7'h0f, 2'h0, 6'h10, 1'b0, 7'h1b, 2'h0, 6'h0f}
// t_xp, rd2pre, t_rc.
`define DDRC_DRAMTMG1 {11'h0, 5'h08, 2'h0, 6'h04, 1'b0, 7'h14}
// wl, rl, rd2wr, wr2rd.
`define DDRC_DRAMTMG2 {2'h0, 6'h03, 2'h0, 6'h05, 2'h0, 6'h06, 2'h0, 6'h0d}
// t_mrd, t_mod.
`define DDRC_DRAMTMG3 {14'h0, 6'h00, 2'h0, 10'h000}
// t_rcd, t_ccd, t_rrd, t_rp.
`define DDRC_DRAMTMG4 {3'h0, 5'h05, 4'h0, 4'h4, 4'h0, 4'h4, 3'h0, 5'h05}
// t_cksrx, t_cksre, t_ckesr, t_cke.
`define DDRC_DRAMTMG5 {4'h0, 4'h5, 4'h0, 4'h5, 2'h0, 6'h04, 3'h0, 5'h03}
// rddata enable latency and phy write latency.
`define DDRC_DFITMG0  {9'b010000000, 7'h02, 1'b1, 9'h0, 6'h02}

//////////////////////////////////////////////////////////////////////
// register table
//////////////////////////////////////////////////////////////////////
`define DDRC_TBL_ADDR_0  12'h000
`define DDRC_TBL_DATA_0  32'h0004_0201
`define DDRC_TBL_ADDR_1  12'h010
`define DDRC_TBL_DATA_1  32'h0000_0010
`define DDRC_TBL_ADDR_2  12'h014
`define DDRC_TBL_DATA_2  32'h0000_3aed
`define DDRC_TBL_ADDR_3  12'h030
`define DDRC_TBL_DATA_3  32'h0000_0004
`define DDRC_TBL_ADDR_4  12'h034
`define DDRC_TBL_DATA_4  32'h0005_0000
`define DDRC_TBL_ADDR_5  12'h038
`define DDRC_TBL_DATA_5  32'h0000_0002
`define DDRC_TBL_ADDR_6  12'h050
`define DDRC_TBL_DATA_6  32'h00f0_e030
`define DDRC_TBL_ADDR_7  12'h060
`define DDRC_TBL_DATA_7  32'h0000_0000
`define DDRC_TBL_ADDR_8  12'h064
`define DDRC_TBL_DATA_8  {4'h0, `DDRC_TREFI, 6'h0, `DDRC_TRFC_MIN}
`define DDRC_TBL_ADDR_9  12'h0d0
`define DDRC_TBL_DATA_9  32'h4007_0002
`define DDRC_TBL_ADDR_10 12'h0d4
`define DDRC_TBL_DATA_10 32'h0004_0006
`define DDRC_TBL_ADDR_11 12'h0dc
`define DDRC_TBL_DATA_11 {`DDRC_MR, `DDRC_EMR}
`define DDRC_TBL_ADDR_12 12'h0e0
`define DDRC_TBL_DATA_12 {`DDRC_EMR2, `DDRC_EMR3}
`define DDRC_TBL_ADDR_13 12'h0e4
`define DDRC_TBL_DATA_13 32'h0009_0000
`define DDRC_TBL_ADDR_14 12'h100
`define DDRC_TBL_DATA_14 `DDRC_DRAMTMG0
`define DDRC_TBL_ADDR_15 12'h104
`define DDRC_TBL_DATA_15 `DDRC_DRAMTMG1
`define DDRC_TBL_ADDR_16 12'h108
`define DDRC_TBL_DATA_16 `DDRC_DRAMTMG2
`define DDRC_TBL_ADDR_17 12'h10c
`define DDRC_TBL_DATA_17 `DDRC_DRAMTMG3
`define DDRC_TBL_ADDR_18 12'h110
`define DDRC_TBL_DATA_18 `DDRC_DRAMTMG4
`define DDRC_TBL_ADDR_19 12'h114
`define DDRC_TBL_DATA_19 `DDRC_DRAMTMG5
`define DDRC_TBL_ADDR_20 12'h190
`define DDRC_TBL_DATA_20 `DDRC_DFITMG0
`define DDRC_TBL_ADDR_21 12'h1b0
`define DDRC_TBL_DATA_21 32'h0000_0001
`define DDRC_TBL_ADDR_22 12'h300
`define DDRC_TBL_DATA_22 32'h0000_0001
`define DDRC_TBL_ADDR_23 12'h320
`define DDRC_TBL_DATA_23 32'h0000_0001

`endif

// ==== hw/ddrc_init_pkg.sv ====
// DDR init shared types
`include "ddrc_init_macros.svh"

package ddrc_init_pkg;

   typedef logic [`DDRC_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`DDRC_REG_DATA_W-1:0] reg_data_t;

   // wide enough to count every table entry.
   typedef logic [$clog2(`DDRC_INIT_ENTRIES)-1:0] tbl_idx_t;

   typedef enum logic [1:0]
   {
      seq_idle,
      seq_run,
      seq_done
   } seq_state_t;

   typedef enum logic [1:0]
   {
      apb_idle,
      apb_setup,
      apb_access,
      apb_done
   } apb_state_t;

endpackage

// ==== hw/init_table_seq.sv ====
// DDR3 register table sequencer
`include "ddrc_init_macros.svh"

module init_table_seq
(
   input  logic                     pclk,
   input  logic                     presetn,
   input  logic                     init_start,
   input  logic                     full,
   output logic                     push,
   output ddrc_init_pkg::reg_addr_t push_addr,
   output ddrc_init_pkg::reg_data_t push_data,
   output logic                     table_done
);

   ddrc_init_pkg::seq_state_t state;
   ddrc_init_pkg::tbl_idx_t   idx;
   logic                      last_entry;

   assign last_entry = (idx == ddrc_init_pkg::tbl_idx_t'(`DDRC_INIT_ENTRIES - 1));
   assign push       = (state == ddrc_init_pkg::seq_run) && !full;
   assign table_done = (state == ddrc_init_pkg::seq_done);

   //////////////////////////////////////////////////////////////////////
   // table walk
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge pclk or negedge presetn)
   begin
      if (!presetn)
      begin
         state <= ddrc_init_pkg::seq_idle;
         idx   <= '0;
      end
      else
      begin
         case (state)
            ddrc_init_pkg::seq_idle:
            begin
               if (init_start) // start is only looked at here.
               begin
                  state <= ddrc_init_pkg::seq_run;
                  idx   <= '0;
               end
            end
            ddrc_init_pkg::seq_run:
            begin
               if (push)
               begin
                  idx <= idx + 1'b1;
                  if (last_entry)
                  begin
                     state <= ddrc_init_pkg::seq_done;
                  end
               end
            end
            default:
            begin
               state <= ddrc_init_pkg::seq_done; // held until reset.
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // table lookup
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      case (idx)
         5'd0:    {push_addr, push_data} = {`DDRC_TBL_ADDR_0, `DDRC_TBL_DATA_0};
         5'd1:    {push_addr, push_data} = {`DDRC_TBL_ADDR_1, `DDRC_TBL_DATA_1};
         5'd2:    {push_addr, push_data} = {`DDRC_TBL_ADDR_2, `DDRC_TBL_DATA_2};
         5'd3:    {push_addr, push_data} = {`DDRC_TBL_ADDR_3, `DDRC_TBL_DATA_3};
         5'd4:    {push_addr, push_data} = {`DDRC_TBL_ADDR_4, `DDRC_TBL_DATA_4};
         5'd5:    {push_addr, push_data} = {`DDRC_TBL_ADDR_5, `DDRC_TBL_DATA_5};
         5'd6:    {push_addr, push_data} = {`DDRC_TBL_ADDR_6, `DDRC_TBL_DATA_6};
         5'd7:    {push_addr, push_data} = {`DDRC_TBL_ADDR_7, `DDRC_TBL_DATA_7};
         5'd8:    {push_addr, push_data} = {`DDRC_TBL_ADDR_8, `DDRC_TBL_DATA_8};
         5'd9:    {push_addr, push_data} = {`DDRC_TBL_ADDR_9, `DDRC_TBL_DATA_9};
         5'd10:   {push_addr, push_data} = {`DDRC_TBL_ADDR_10, `DDRC_TBL_DATA_10};
         5'd11:   {push_addr, push_data} = {`DDRC_TBL_ADDR_11, `DDRC_TBL_DATA_11};
         5'd12:   {push_addr, push_data} = {`DDRC_TBL_ADDR_12, `DDRC_TBL_DATA_12};
         5'd13:   {push_addr, push_data} = {`DDRC_TBL_ADDR_13, `DDRC_TBL_DATA_13};
         5'd14:   {push_addr, push_data} = {`DDRC_TBL_ADDR_14, `DDRC_TBL_DATA_14};
         5'd15:   {push_addr, push_data} = {`DDRC_TBL_ADDR_15, `DDRC_TBL_DATA_15};
         5'd16:   {push_addr, push_data} = {`DDRC_TBL_ADDR_16, `DDRC_TBL_DATA_16};
         5'd17:   {push_addr, push_data} = {`DDRC_TBL_ADDR_17, `DDRC_TBL_DATA_17};
         5'd18:   {push_addr, push_data} = {`DDRC_TBL_ADDR_18, `DDRC_TBL_DATA_18};
         5'd19:   {push_addr, push_data} = {`DDRC_TBL_ADDR_19, `DDRC_TBL_DATA_19};
         5'd20:   {push_addr, push_data} = {`DDRC_TBL_ADDR_20, `DDRC_TBL_DATA_20};
         5'd21:   {push_addr, push_data} = {`DDRC_TBL_ADDR_21, `DDRC_TBL_DATA_21};
         5'd22:   {push_addr, push_data} = {`DDRC_TBL_ADDR_22, `DDRC_TBL_DATA_22};
         5'd23:   {push_addr, push_data} = {`DDRC_TBL_ADDR_23, `DDRC_TBL_DATA_23};
         default: {push_addr, push_data} = '0;
      endcase
   end

endmodule

// ==== hw/cfg_write_fifo.sv ====
// Pending register write FIFO
`include "ddrc_init_macros.svh"

module cfg_write_fifo #(
   parameter int DEPTH = `CFG_FIFO_DEPTH
)
(
   input  logic                     pclk,
   input  logic                     presetn,
   input  logic                     push,
   input  ddrc_init_pkg::reg_addr_t push_addr,
   input  ddrc_init_pkg::reg_data_t push_data,
   input  logic                     pop,
   output logic                     full,
   output logic                     empty,
   output ddrc_init_pkg::reg_addr_t pop_addr,
   output ddrc_init_pkg::reg_data_t pop_data
);

   localparam int PTR_W = $clog2(DEPTH);

   ddrc_init_pkg::reg_addr_t addr_mem [DEPTH];
   ddrc_init_pkg::reg_data_t data_mem [DEPTH];
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;
   logic [PTR_W:0]           count;
   logic                     wr_en;
   logic                     rd_en;

   assign wr_en    = push && !full;
   assign rd_en    = pop && !empty;
   assign full     = (count == (PTR_W+1)'(DEPTH));
   assign empty    = (count == '0);
   assign pop_addr = addr_mem[rd_ptr]; // head entry, valid while not empty.
   assign pop_data = data_mem[rd_ptr];

   always_ff @(posedge pclk)
   begin
      if (wr_en)
      begin
         addr_mem[wr_ptr] <= push_addr;
         data_mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap on their own since the depth is a power of two.
   always_ff @(posedge pclk or negedge presetn)
   begin
      if (!presetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== hw/apb_cfg_master.sv ====
// APB configuration master
`include "ddrc_init_macros.svh"

module apb_cfg_master
(
   input  logic                     pclk,
   input  logic                     presetn,
   input  logic                     empty,
   input  ddrc_init_pkg::reg_addr_t pop_addr,
   input  ddrc_init_pkg::reg_data_t pop_data,
   input  logic                     table_done,
   output logic                     pop,
   output logic                     psel,
   output logic                     penable,
   output logic                     pwrite,
   output ddrc_init_pkg::reg_addr_t paddr,
   output ddrc_init_pkg::reg_data_t pwdata,
   input  ddrc_init_pkg::reg_data_t prdata,
   input  logic                     pready,
   output logic                     init_done
);

   ddrc_init_pkg::apb_state_t state;
   logic                      done_seen;

   assign psel      = (state == ddrc_init_pkg::apb_setup) ||
                      (state == ddrc_init_pkg::apb_access);
   assign penable   = (state == ddrc_init_pkg::apb_access);
   assign pop       = (state == ddrc_init_pkg::apb_setup) && pwrite;
   assign init_done = (state == ddrc_init_pkg::apb_done);

   // a status read that returns the done code ends the sequence.
   assign done_seen = !pwrite && (prdata[1:0] == `DDRC_DONE_CODE);

   //////////////////////////////////////////////////////////////////////
   // transfer FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge pclk or negedge presetn)
   begin
      if (!presetn)
      begin
         state  <= ddrc_init_pkg::apb_idle;
         pwrite <= 1'b0;
         paddr  <= '0;
         pwdata <= '0;
      end
      else
      begin
         case (state)
            ddrc_init_pkg::apb_idle:
            begin
               if (!empty)
               begin
                  state  <= ddrc_init_pkg::apb_setup;
                  pwrite <= 1'b1;
                  paddr  <= pop_addr; // head entry, popped during setup.
                  pwdata <= pop_data;
               end
               else if (table_done)
               begin
                  state  <= ddrc_init_pkg::apb_setup;
                  pwrite <= 1'b0;
                  paddr  <= `DDRC_STAT_ADDR;
                  pwdata <= '0;
               end
            end
            ddrc_init_pkg::apb_setup:
            begin
               state <= ddrc_init_pkg::apb_access;
            end
            ddrc_init_pkg::apb_access:
            begin
               if (pready)
               begin
                  pwrite <= 1'b0;
                  paddr  <= '0;
                  pwdata <= '0;
                  if (done_seen)
                  begin
                     state <= ddrc_init_pkg::apb_done;
                  end
                  else
                  begin
                     state <= ddrc_init_pkg::apb_idle;
                  end
               end
            end
            default:
            begin
               state <= ddrc_init_pkg::apb_done; // parked until reset.
            end
         endcase
      end
   end

endmodule

// ==== hw/ddrc_apb_init.sv ====
// DDR controller APB init engine

module ddrc_apb_init
(
   input  logic                     pclk,
   input  logic                     presetn,
   output logic                     psel,
   output logic                     penable,
   output logic                     pwrite,
   output ddrc_init_pkg::reg_addr_t paddr,
   output ddrc_init_pkg::reg_data_t pwdata,
   input  ddrc_init_pkg::reg_data_t prdata,
   input  logic                     pready,
   input  logic                     init_start,
   output logic                     init_done
);

   logic                     push;
   logic                     full;
   logic                     pop;
   logic                     empty;
   logic                     table_done;
   ddrc_init_pkg::reg_addr_t push_addr;
   ddrc_init_pkg::reg_data_t push_data;
   ddrc_init_pkg::reg_addr_t pop_addr;
   ddrc_init_pkg::reg_data_t pop_data;

   init_table_seq i_seq
   (
      .pclk       (pclk),
      .presetn    (presetn),
      .init_start (init_start),
      .full       (full),
      .push       (push),
      .push_addr  (push_addr),
      .push_data  (push_data),
      .table_done (table_done)
   );

   // lets the table run ahead of slow pready responses.
   cfg_write_fifo i_fifo
   (
      .pclk      (pclk),
      .presetn   (presetn),
      .push      (push),
      .push_addr (push_addr),
      .push_data (push_data),
      .pop       (pop),
      .full      (full),
      .empty     (empty),
      .pop_addr  (pop_addr),
      .pop_data  (pop_data)
   );

   apb_cfg_master i_master
   (
      .pclk       (pclk),
      .presetn    (presetn),
      .empty      (empty),
      .pop_addr   (pop_addr),
      .pop_data   (pop_data),
      .table_done (table_done),
      .pop        (pop),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .init_done  (init_done)
   );

endmodule

// ==== verif/ddrc_apb_slave_model.sv ====
// APB responder model
`include "ddrc_init_macros.svh"

module ddrc_apb_slave_model #(
   parameter int POLLS_BEFORE_DONE = 3
)
(
   input  logic                     pclk,
   input  logic                     presetn,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  ddrc_init_pkg::reg_addr_t paddr,
   input  ddrc_init_pkg::reg_data_t pwdata,
   output ddrc_init_pkg::reg_data_t prdata,
   output logic                     pready
);

   ddrc_init_pkg::reg_addr_t log_addr [64];
   ddrc_init_pkg::reg_data_t log_data [64];
   int                       wr_count;
   int                       rd_count;
   int                       wait_left;
   logic                     done_sent;
   logic [31:0]              rng;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial
   begin
      rng       = 32'he71e;
      wr_count  = 0;
      rd_count  = 0;
      wait_left = 0;
      done_sent = 1'b0;
      pready    = 1'b0;
      prdata    = '0;
   end

   // responses change on the falling edge and are sampled by the DUT on the rising one.
   always @(negedge pclk)
   begin
      pready = 1'b0;
      prdata = '0;
      if (!presetn)
      begin
         wait_left = 0;
      end
      else if (psel && !penable)
      begin
         rng       = xorshift(rng);
         wait_left = int'(rng[1:0]); // zero to three wait states.
      end
      else if (psel && penable)
      begin
         if (wait_left > 0)
         begin
            wait_left = wait_left - 1;
         end
         else
         begin
            pready = 1'b1;
            if (pwrite)
            begin
               if (wr_count < 64)
               begin
                  log_addr[wr_count] = paddr;
                  log_data[wr_count] = pwdata;
               end
               wr_count = wr_count + 1;
            end
            else
            begin
               if (rd_count >= POLLS_BEFORE_DONE)
               begin
                  prdata    = {30'h0, `DDRC_DONE_CODE};
                  done_sent = 1'b1;
               end
               rd_count = rd_count + 1;
            end
         end
      end
   end

endmodule

// ==== verif/ddrc_apb_init_tb.sv ====
// DDR init engine testbench
`include "ddrc_init_macros.svh"

module ddrc_apb_init_tb;

   localparam int POLLS   = 3;
   localparam int TIMEOUT = 2000;

   logic                     pclk;
   logic                     presetn;
   logic                     init_start;
   logic                     psel;
   logic                     penable;
   logic                     pwrite;
   logic                     pready;
   logic                     init_done;
   ddrc_init_pkg::reg_addr_t paddr;
   ddrc_init_pkg::reg_data_t pwdata;
   ddrc_init_pkg::reg_data_t prdata;

   int                       tests;
   int                       failed_tests;
   int                       checks;
   int                       errors;
   int                       test_errors;
   int                       proto_errors;
   int                       compared;
   int                       full_cycles;
   int                       cycles;
   logic                     prev_psel;
   logic                     prev_pwrite;
   logic                     prev_done;
   logic                     xfer_done;
   ddrc_init_pkg::reg_addr_t prev_paddr;
   ddrc_init_pkg::reg_data_t prev_pwdata;
   logic [`DDRC_REG_ADDR_W+`DDRC_REG_DATA_W-1:0] exp_entry;

   ddrc_apb_init i_dut
   (
      .pclk       (pclk),
      .presetn    (presetn),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .init_start (init_start),
      .init_done  (init_done)
   );

   ddrc_apb_slave_model #(.POLLS_BEFORE_DONE(POLLS)) i_slave
   (
      .pclk    (pclk),
      .presetn (presetn),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready)
   );

   always #10 pclk = ~pclk;

   //////////////////////////////////////////////////////////////////////
   // reference table and reporting
   //////////////////////////////////////////////////////////////////////
   function automatic logic [`DDRC_REG_ADDR_W+`DDRC_REG_DATA_W-1:0] ref_entry(input int n);
      case (n)
         0:       return {`DDRC_TBL_ADDR_0, `DDRC_TBL_DATA_0};
         1:       return {`DDRC_TBL_ADDR_1, `DDRC_TBL_DATA_1};
         2:       return {`DDRC_TBL_ADDR_2, `DDRC_TBL_DATA_2};
         3:       return {`DDRC_TBL_ADDR_3, `DDRC_TBL_DATA_3};
         4:       return {`DDRC_TBL_ADDR_4, `DDRC_TBL_DATA_4};
         5:       return {`DDRC_TBL_ADDR_5, `DDRC_TBL_DATA_5};
         6:       return {`DDRC_TBL_ADDR_6, `DDRC_TBL_DATA_6};
         7:       return {`DDRC_TBL_ADDR_7, `DDRC_TBL_DATA_7};
         8:       return {`DDRC_TBL_ADDR_8, `DDRC_TBL_DATA_8};
         9:       return {`DDRC_TBL_ADDR_9, `DDRC_TBL_DATA_9};
         10:      return {`DDRC_TBL_ADDR_10, `DDRC_TBL_DATA_10};
         11:      return {`DDRC_TBL_ADDR_11, `DDRC_TBL_DATA_11};
         12:      return {`DDRC_TBL_ADDR_12, `DDRC_TBL_DATA_12};
         13:      return {`DDRC_TBL_ADDR_13, `DDRC_TBL_DATA_13};
         14:      return {`DDRC_TBL_ADDR_14, `DDRC_TBL_DATA_14};
         15:      return {`DDRC_TBL_ADDR_15, `DDRC_TBL_DATA_15};
         16:      return {`DDRC_TBL_ADDR_16, `DDRC_TBL_DATA_16};
         17:      return {`DDRC_TBL_ADDR_17, `DDRC_TBL_DATA_17};
         18:      return {`DDRC_TBL_ADDR_18, `DDRC_TBL_DATA_18};
         19:      return {`DDRC_TBL_ADDR_19, `DDRC_TBL_DATA_19};
         20:      return {`DDRC_TBL_ADDR_20, `DDRC_TBL_DATA_20};
         21:      return {`DDRC_TBL_ADDR_21, `DDRC_TBL_DATA_21};
         22:      return {`DDRC_TBL_ADDR_22, `DDRC_TBL_DATA_22};
         23:      return {`DDRC_TBL_ADDR_23, `DDRC_TBL_DATA_23};
         default: return '0;
      endcase
   endfunction

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         test_errors++;
         $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      end
   endtask

   task automatic report_violation(input string what);
      errors++;
      proto_errors++;
      $display("protocol error at time %0t: %s", $time, what);
   endtask

   task automatic end_test(input string name, input int errs);
      tests++;
      if (errs == 0)
      begin
         $display("test %s: passed", name);
      end
      else
      begin
         failed_tests++;
         $display("test %s: %0d errors", name, errs);
      end
   endtask

   task automatic check_bus_idle(input string name);
      check_equal({name, ": psel"}, 32'd0, 32'(psel));
      check_equal({name, ": penable"}, 32'd0, 32'(penable));
      check_equal({name, ": init_done"}, 32'd0, 32'(init_done));
      check_equal({name, ": paddr"}, 32'd0, 32'(paddr));
      check_equal({name, ": pwdata"}, 32'd0, pwdata);
   endtask

   //////////////////////////////////////////////////////////////////////
   // monitors
   //////////////////////////////////////////////////////////////////////
   // the slave logs on the falling edge, so its log is stable here.
   always @(posedge pclk)
   begin
      while (compared < i_slave.wr_count)
      begin
         exp_entry = ref_entry(compared);
         check_equal($sformatf("table_writes: entry %0d address", compared),
                     32'(exp_entry[`DDRC_REG_ADDR_W+`DDRC_REG_DATA_W-1:`DDRC_REG_DATA_W]),
                     32'(i_slave.log_addr[compared]));
         check_equal($sformatf("table_writes: entry %0d data", compared),
                     exp_entry[`DDRC_REG_DATA_W-1:0], i_slave.log_data[compared]);
         compared++;
      end
      if (i_dut.full)
      begin
         full_cycles++;
      end
      // a transfer completes on this edge when pready is up in an access phase.
      xfer_done = psel && penable && pready;
   end

   always @(negedge pclk)
   begin
      if (presetn)
      begin
         if (penable && !psel)
            report_violation("penable is high while psel is low");
         if (penable && (!prev_psel || xfer_done))
            report_violation("access phase was not preceded by a setup phase");
         if (penable && (paddr !== prev_paddr || pwrite !== prev_pwrite || pwdata !== prev_pwdata))
            report_violation("address, direction or write data changed during a transfer");
         if (!psel && (penable || paddr !== '0 || pwdata !== '0))
            report_violation("bus is not quiet between transfers");
         if (psel && !pwrite && paddr !== `DDRC_STAT_ADDR)
            report_violation("a read went to an address other than the status register");
         if (psel && !pwrite && i_slave.wr_count != `DDRC_INIT_ENTRIES)
            report_violation("status polling started before all table writes completed");
         if (init_done && psel)
            report_violation("a transfer started after init_done");
         if (init_done && !prev_done && !i_slave.done_sent)
            report_violation("init_done rose before the done status was returned");
      end
      prev_psel   = psel;
      prev_pwrite = pwrite;
      prev_paddr  = paddr;
      prev_pwdata = pwdata;
      prev_done   = init_done;
   end

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      pclk         = 1'b0;
      presetn      = 1'b0;
      init_start   = 1'b0;
      tests        = 0;
      failed_tests = 0;
      checks       = 0;
      errors       = 0;
      proto_errors = 0;
      compared     = 0;
      full_cycles  = 0;
      test_errors  = 0;

      repeat (10)
      begin
         @(negedge pclk);
         check_bus_idle("reset_idle");
      end
      presetn = 1'b1;
      repeat (5)
      begin
         @(negedge pclk);
         check_bus_idle("reset_idle"); // start is still low.
      end
      end_test("reset_idle", test_errors);

      test_errors = 0;
      init_start  = 1'b1;
      cycles      = 0;
      while (i_slave.wr_count < `DDRC_INIT_ENTRIES && cycles < TIMEOUT)
      begin
         @(posedge pclk);
         cycles++;
      end
      @(negedge pclk);
      if (cycles >= TIMEOUT)
      begin
         errors++;
         test_errors++;
         $display("timeout while waiting for the table writes to complete");
      end
      check_equal("table_writes: entries compared", `DDRC_INIT_ENTRIES, compared);
      end_test("table_writes", test_errors);

      test_errors = 0;
      cycles      = 0;
      while (!init_done && cycles < TIMEOUT)
      begin
         @(posedge pclk);
         cycles++;
      end
      if (cycles >= TIMEOUT)
      begin
         errors++;
         test_errors++;
         $display("timeout while waiting for init_done");
      end
      repeat (20) @(negedge pclk); // the bus must stay quiet after init_done.
      check_equal("status_poll: init_done", 32'd1, 32'(init_done));
      check_equal("status_poll: status reads", POLLS + 1, i_slave.rd_count);
      check_equal("status_poll: done code returned", 32'd1, 32'(i_slave.done_sent));
      end_test("status_poll", test_errors);

      test_errors = 0;
      check_equal("fifo_backpressure: fifo reached full", 32'd1, (full_cycles > 0) ? 32'd1 : 32'd0);
      check_equal("fifo_backpressure: completed writes", `DDRC_INIT_ENTRIES, i_slave.wr_count);
      end_test("fifo_backpressure", test_errors);

      end_test("protocol", proto_errors);

      $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+include
hw/ddrc_init_pkg.sv
hw/init_table_seq.sv
hw/cfg_write_fifo.sv
hw/apb_cfg_master.sv
hw/ddrc_apb_init.sv
verif/ddrc_apb_slave_model.sv
verif/ddrc_apb_init_tb.sv
